//--- common/opcodes.sv
// instruction set definitions: opcodes, ALU functions, flag and field positions
package opcodes;

	// instruction opcodes, taken from IR[15:11]
	typedef enum logic [4:0] {
		opAdd  = 5'h00,
		opAdc  = 5'h01,
		opSub  = 5'h02,
		opAnd  = 5'h03,
		opOr   = 5'h04,
		opXor  = 5'h05,
		opAddi = 5'h08, // rd + sign extended imm8
		opLdw  = 5'h10,
		opStw  = 5'h11,
		opBeq  = 5'h14,
		opBl   = 5'h18,
		opRet  = 5'h19,
		opHalt = 5'h1f
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd,
		aluAdc,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluPassB
	} aluFunctionT;

	// flag bit positions
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

	localparam logic [2:0] linkReg = 3'd7; // BL writes the return address here

	// instruction field positions
	localparam int opMsb   = 15;
	localparam int opLsb   = 11;
	localparam int rdMsb   = 10;
	localparam int rdLsb   = 8;
	localparam int raMsb   = 7;
	localparam int raLsb   = 5;
	localparam int rbMsb   = 4;
	localparam int rbLsb   = 2;
	localparam int imm5Msb = 4; // LDW / STW offset
	localparam int imm8Msb = 7; // ADDI, BEQ, BL

endpackage

//--- common/datapathPkg.sv
// datapath control definitions: word width and mux select encodings
package datapathPkg;

	localparam int dataWidth = 16;

	// sign extension source
	typedef enum logic {immShort, immByte} immSelectT;

	typedef enum logic {op1Rd1, op1Pc} op1SelectT;

	typedef enum logic [1:0] {op2Rd2, op2Imm, op2Zero} op2SelectT;

	// next PC source
	typedef enum logic [1:0] {pcLr, pcAluOut, pcSysBus, pcPc1} pcSelectT;

	typedef enum logic {lrPc, lrSysBus} lrSelectT;

	// first register read address
	typedef enum logic {rs1Rd, rs1Ra} rs1SelectT;

	// register write address
	typedef enum logic [1:0] {rwSeven, rwRd, rwRa} rwSelectT;

	typedef enum logic {wdSys, wdAlu} wdSelectT;

	// force add for address and branch target arithmetic
	typedef enum logic {aluOrOpcode, aluOrForceAdd} aluOrSelectT;

endpackage

//--- datapath/trisreg.sv
// word register with write enable and a tristate driver onto the system bus
`timescale 1ns/1ps

module trisreg (
	input  logic                             Clock,
	input  logic                             rstN,
	input  logic                             regEn,   // drive the bus
	input  logic                             regWe,
	input  logic [datapathPkg::dataWidth-1:0] dataIn,
	output logic [datapathPkg::dataWidth-1:0] dataOut,
	inout  wire  [datapathPkg::dataWidth-1:0] trisOut
);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			dataOut <= '0;
		end else if (regWe) begin
			dataOut <= dataIn;
		end
	end

	assign trisOut = regEn ? dataOut : 'z; // released when not enabled

endmodule

//--- datapath/regBlock.sv
// eight entry register file, two asynchronous reads and one synchronous write
`timescale 1ns/1ps

module regBlock (
	input  logic                             Clock,
	input  logic                             rstN,
	input  logic                             we,
	input  logic [2:0]                       rs1,
	input  logic [2:0]                       rs2,
	input  logic [2:0]                       rw,
	input  logic [datapathPkg::dataWidth-1:0] wData,
	output logic [datapathPkg::dataWidth-1:0] rd1,
	output logic [datapathPkg::dataWidth-1:0] rd2
);

	// r7 is also the link register target of BL
	logic [datapathPkg::dataWidth-1:0] regs [8];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

//--- datapath/aluDecode.sv
// opcode to ALU function decoder
`timescale 1ns/1ps

module aluDecode (
	input  opcodes::opcodeT      opCode,
	output opcodes::aluFunctionT aluOp
);

	always_comb begin
		case (opCode)
			opcodes::opAdd:  aluOp = opcodes::aluAdd;
			opcodes::opAdc:  aluOp = opcodes::aluAdc;
			opcodes::opSub:  aluOp = opcodes::aluSub;
			opcodes::opAnd:  aluOp = opcodes::aluAnd;
			opcodes::opOr:   aluOp = opcodes::aluOr;
			opcodes::opXor:  aluOp = opcodes::aluXor;
			opcodes::opAddi: aluOp = opcodes::aluAdd;
			// loads, stores and branches only need an adder
			default:         aluOp = opcodes::aluAdd;
		endcase
	end

endmodule

//--- datapath/alu.sv
// combinational ALU with N, Z, C and V flag outputs
`timescale 1ns/1ps

module alu (
	input  logic [datapathPkg::dataWidth-1:0] op1,
	input  logic [datapathPkg::dataWidth-1:0] op2,
	input  logic                             carryIn,
	input  opcodes::aluFunctionT             aluOp,
	input  datapathPkg::aluOrSelectT         aluOR,
	output logic [datapathPkg::dataWidth-1:0] result,
	output logic [3:0]                       flags
);

	localparam int msb = datapathPkg::dataWidth - 1;

	opcodes::aluFunctionT func;
	logic [msb:0] bOperand;
	logic [msb+1:0] sum; // carry out in the top bit
	logic cin;
	logic isArith;

	always_comb begin
		func = (aluOR == datapathPkg::aluOrForceAdd) ? opcodes::aluAdd : aluOp;
		// subtract as op1 + ~op2 + 1
		bOperand = (func == opcodes::aluSub) ? ~op2 : op2;
		case (func)
			opcodes::aluSub: cin = 1'b1;
			opcodes::aluAdc: cin = carryIn;
			default:         cin = 1'b0;
		endcase
		sum = {1'b0, op1} + {1'b0, bOperand} + {{(msb + 1){1'b0}}, cin};
		isArith = (func == opcodes::aluAdd) || (func == opcodes::aluAdc) ||
			(func == opcodes::aluSub);

		case (func)
			opcodes::aluAnd:   result = op1 & op2;
			opcodes::aluOr:    result = op1 | op2;
			opcodes::aluXor:   result = op1 ^ op2;
			opcodes::aluPassB: result = op2;
			default:           result = sum[msb:0];
		endcase

		flags[opcodes::flagN] = result[msb];
		flags[opcodes::flagZ] = (result == '0);
		flags[opcodes::flagC] = isArith & sum[msb+1];
		// overflow when both inputs share a sign the result lacks
		flags[opcodes::flagV] = isArith & (op1[msb] == bOperand[msb]) & (sum[msb] != op1[msb]);
	end

endmodule

//--- datapath/datapath.sv
// processor datapath: shared system bus, register file, ALU and special registers
`timescale 1ns/1ps

module datapath (
	output logic [3:0]                       Flags,
	output logic [datapathPkg::dataWidth-1:0] Ir,
	output logic [datapathPkg::dataWidth-1:0] Addr,
	inout  wire  [datapathPkg::dataWidth-1:0] SysBus,
	input  logic                             AddrSel,
	input  logic                             AddrWe,
	input  logic                             AluEn,
	input  logic                             AluWe,
	input  logic                             CFlag,
	input  logic                             Clock,
	input  logic [datapathPkg::dataWidth-1:0] DataIn,
	input  datapathPkg::immSelectT           ImmSel,
	input  logic                             IrWe,
	input  logic                             LrEn,
	input  datapathPkg::lrSelectT            LrSel,
	input  logic                             LrWe,
	input  logic                             MemEn,
	input  logic                             rstN,
	input  datapathPkg::op1SelectT           Op1Sel,
	input  datapathPkg::op2SelectT           Op2Sel,
	input  logic                             PcEn,
	input  datapathPkg::pcSelectT            PcSel,
	input  logic                             PcWe,
	input  logic                             RegWe,
	input  datapathPkg::rs1SelectT           Rs1Sel,
	input  datapathPkg::rwSelectT            RwSel,
	input  datapathPkg::aluOrSelectT         AluOR,
	input  datapathPkg::wdSelectT            WdSel
);

	localparam int w = datapathPkg::dataWidth;

	opcodes::opcodeT OpCode;
	opcodes::aluFunctionT AluOp;
	logic [w-1:0] AluRes, Rd1, Rd2, WData, Extended, PcInc;
	logic [w-1:0] Op1, Op2, Pc, PcIn, Lr, LrIn, Mar;
	logic [2:0] Rs1In, Rw;

	assign OpCode = opcodes::opcodeT'(Ir[opcodes::opMsb:opcodes::opLsb]);

	always_comb begin
		if (ImmSel == datapathPkg::immShort) begin
			Extended = {{(w - opcodes::imm5Msb - 1){Ir[opcodes::imm5Msb]}}, Ir[opcodes::imm5Msb:0]};
		end else begin
			Extended = {{(w - opcodes::imm8Msb - 1){Ir[opcodes::imm8Msb]}}, Ir[opcodes::imm8Msb:0]};
		end
	end

	assign SysBus = MemEn ? DataIn : 'z; // memory read data onto the bus
	assign WData = (WdSel == datapathPkg::wdSys) ? SysBus : AluRes;
	assign LrIn = (LrSel == datapathPkg::lrPc) ? PcInc : SysBus;
	assign PcInc = Pc + 1'b1;
	assign Op1 = (Op1Sel == datapathPkg::op1Pc) ? Pc : Rd1;
	assign Addr = AddrSel ? Mar : Pc; // APB address, PC on fetch

	always_comb begin
		case (Op2Sel)
			datapathPkg::op2Imm:  Op2 = Extended;
			datapathPkg::op2Zero: Op2 = '0;
			default:              Op2 = Rd2;
		endcase
		case (Rs1Sel)
			datapathPkg::rs1Ra: Rs1In = Ir[opcodes::raMsb:opcodes::raLsb];
			default:            Rs1In = Ir[opcodes::rdMsb:opcodes::rdLsb];
		endcase
		case (RwSel)
			datapathPkg::rwSeven: Rw = opcodes::linkReg;
			datapathPkg::rwRa:    Rw = Ir[opcodes::raMsb:opcodes::raLsb];
			default:              Rw = Ir[opcodes::rdMsb:opcodes::rdLsb];
		endcase
		case (PcSel)
			datapathPkg::pcLr:     PcIn = Lr;
			datapathPkg::pcAluOut: PcIn = AluRes;  // branch target
			datapathPkg::pcSysBus: PcIn = SysBus;
			default:               PcIn = PcInc;
		endcase
	end

	regBlock regs (
		.Clock (Clock),
		.rstN  (rstN),
		.we    (RegWe),
		.rs1   (Rs1In),
		.rs2   (Ir[opcodes::rbMsb:opcodes::rbLsb]),
		.rw    (Rw),
		.wData (WData),
		.rd1   (Rd1),
		.rd2   (Rd2)
	);

	aluDecode dec (
		.opCode (OpCode),
		.aluOp  (AluOp)
	);

	alu alu0 (
		.op1     (Op1),
		.op2     (Op2),
		.carryIn (CFlag),
		.aluOp   (AluOp),
		.aluOR   (AluOR),
		.result  (AluRes),
		.flags   (Flags)
	);

	trisreg regPc (
		.Clock (Clock), .rstN (rstN), .regEn (PcEn), .regWe (PcWe),
		.dataIn (PcIn), .dataOut (Pc), .trisOut (SysBus)
	);

	trisreg regLr (
		.Clock (Clock), .rstN (rstN), .regEn (LrEn), .regWe (LrWe),
		.dataIn (LrIn), .dataOut (Lr), .trisOut (SysBus)
	);

	// IR only listens to the bus
	trisreg regIr (
		.Clock (Clock), .rstN (rstN), .regEn (1'b0), .regWe (IrWe),
		.dataIn (SysBus), .dataOut (Ir), .trisOut ()
	);

	trisreg regAluOut (
		.Clock (Clock), .rstN (rstN), .regEn (AluEn), .regWe (AluWe),
		.dataIn (AluRes), .dataOut (), .trisOut (SysBus)
	);

	// memory address for LDW / STW, frees ALUOUT to carry store data
	trisreg regMar (
		.Clock (Clock), .rstN (rstN), .regEn (1'b0), .regWe (AddrWe),
		.dataIn (AluRes), .dataOut (Mar), .trisOut ()
	);

endmodule

//--- design/control.sv
// multicycle controller: instruction sequencing, flag register and APB master
`timescale 1ns/1ps

module control (
	input  logic                              Clock,
	input  logic                              rstN,
	input  logic [datapathPkg::dataWidth-1:0] ir,
	input  logic [3:0]                        flags,
	output logic                              AddrSel,
	output logic                              AddrWe,
	output logic                              AluEn,
	output logic                              AluWe,
	output datapathPkg::immSelectT            ImmSel,
	output logic                              IrWe,
	output logic                              LrEn,
	output datapathPkg::lrSelectT             LrSel,
	output logic                              LrWe,
	output logic                              MemEn,
	output datapathPkg::op1SelectT            Op1Sel,
	output datapathPkg::op2SelectT            Op2Sel,
	output logic                              PcEn,
	output datapathPkg::pcSelectT             PcSel,
	output logic                              PcWe,
	output logic                              RegWe,
	output datapathPkg::rs1SelectT            Rs1Sel,
	output datapathPkg::rwSelectT             RwSel,
	output datapathPkg::aluOrSelectT          AluOR,
	output datapathPkg::wdSelectT             WdSel,
	output logic                              cFlag,
	output logic                              psel,
	output logic                              penable,
	output logic                              pwrite,
	input  logic                              pready,
	output logic                              halted
);

	typedef enum logic [2:0] {
		stFetchSetup, stFetchAccess, stDecode, stExecute,
		stMemSetup, stMemAccess, stWriteback, stHalted
	} stateT;

	stateT state, nextState;
	opcodes::opcodeT opCode;
	logic running;     // low for the first cycle out of reset
	logic [3:0] flagReg;
	logic flagWe;
	logic isAlu, isMem, isStore;

	assign opCode = opcodes::opcodeT'(ir[opcodes::opMsb:opcodes::opLsb]);
	assign isStore = (opCode == opcodes::opStw);
	assign isMem = isStore || (opCode == opcodes::opLdw);
	assign isAlu = (opCode inside {opcodes::opAdd, opcodes::opAdc, opcodes::opSub,
		opcodes::opAnd, opcodes::opOr, opcodes::opXor, opcodes::opAddi});

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= stFetchSetup;
			running <= 1'b0;
			flagReg <= '0;
		end else begin
			state <= nextState;
			running <= 1'b1;
			if (flagWe) flagReg <= flags;
		end
	end

	assign cFlag = flagReg[opcodes::flagC];
	assign halted = (state == stHalted);

	// APB master phases follow the state
	assign psel = ((state == stFetchSetup) && running) || (state == stFetchAccess) ||
		(state == stMemSetup) || (state == stMemAccess);
	assign penable = (state == stFetchAccess) || (state == stMemAccess);
	assign pwrite = ((state == stMemSetup) || (state == stMemAccess)) && isStore;

	always_comb begin
		nextState = state;
		{AddrSel, AddrWe, AluEn, AluWe, IrWe, LrEn, LrWe, MemEn} = '0;
		{PcEn, PcWe, RegWe, flagWe} = '0;
		ImmSel = datapathPkg::immByte;
		LrSel = datapathPkg::lrSysBus;
		Op1Sel = datapathPkg::op1Rd1;
		Op2Sel = datapathPkg::op2Rd2;
		PcSel = datapathPkg::pcPc1;
		Rs1Sel = datapathPkg::rs1Rd;
		RwSel = datapathPkg::rwRd;
		AluOR = datapathPkg::aluOrOpcode;
		WdSel = datapathPkg::wdAlu;

		case (state)
			stFetchSetup: if (running) nextState = stFetchAccess;
			stFetchAccess: begin
				MemEn = 1'b1; // prdata onto the bus
				if (pready) begin
					IrWe = 1'b1;
					PcWe = 1'b1; // PC now points past this instruction
					nextState = stDecode;
				end
			end
			stDecode: begin
				if (isMem) begin // ra + imm5 into the address register
					AddrWe = 1'b1;
					Rs1Sel = datapathPkg::rs1Ra;
					Op2Sel = datapathPkg::op2Imm;
					ImmSel = datapathPkg::immShort;
					AluOR = datapathPkg::aluOrForceAdd;
				end
				nextState = stExecute;
			end
			stExecute: begin
				nextState = isMem ? stMemSetup : stWriteback;
				if (isAlu) begin
					AluWe = 1'b1;
					flagWe = 1'b1;
					if (opCode == opcodes::opAddi) begin
						Op2Sel = datapathPkg::op2Imm;
					end else begin
						Rs1Sel = datapathPkg::rs1Ra;
					end
				end else if (isStore) begin // rd + 0 as store data
					AluWe = 1'b1;
					Op2Sel = datapathPkg::op2Zero;
					AluOR = datapathPkg::aluOrForceAdd;
				end else if (opCode == opcodes::opHalt) begin
					nextState = stHalted;
				end
			end
			stMemSetup: begin
				AddrSel = 1'b1;
				AluEn = isStore;
				nextState = stMemAccess;
			end
			stMemAccess: begin
				AddrSel = 1'b1;
				AluEn = isStore;
				MemEn = !isStore;
				RegWe = !isStore && pready; // load lands on the completing edge
				WdSel = datapathPkg::wdSys;
				if (pready) nextState = stWriteback;
			end
			stWriteback: begin
				nextState = stFetchSetup;
				WdSel = datapathPkg::wdSys;
				Op1Sel = datapathPkg::op1Pc; // target is PC+1+imm8
				Op2Sel = datapathPkg::op2Imm;
				AluOR = datapathPkg::aluOrForceAdd;
				PcSel = datapathPkg::pcAluOut;
				case (opCode)
					opcodes::opBeq: PcWe = flagReg[opcodes::flagZ];
					opcodes::opBl: begin
						PcEn = 1'b1; // return address to LR and r7
						LrWe = 1'b1;
						RegWe = 1'b1;
						RwSel = datapathPkg::rwSeven;
						PcWe = 1'b1;
					end
					opcodes::opRet: begin
						LrEn = 1'b1;
						PcSel = datapathPkg::pcSysBus;
						PcWe = 1'b1;
					end
					default: begin
						AluEn = isAlu;
						RegWe = isAlu;
					end
				endcase
			end
			default: nextState = stHalted; // stays until reset
		endcase
	end

endmodule

//--- design/cpu.sv
// processor top level: controller and datapath behind one APB master port
`timescale 1ns/1ps

module cpu (
	input  logic                              Clock,
	input  logic                              rstN,
	output logic [datapathPkg::dataWidth-1:0] paddr,
	output logic [datapathPkg::dataWidth-1:0] pwdata,
	input  logic [datapathPkg::dataWidth-1:0] prdata,
	output logic                              psel,
	output logic                              penable,
	output logic                              pwrite,
	input  logic                              pready,
	output logic                              halted
);

	wire [datapathPkg::dataWidth-1:0] SysBus;
	logic [datapathPkg::dataWidth-1:0] Ir;
	logic [3:0] Flags;
	logic AddrSel, AddrWe, AluEn, AluWe, IrWe, LrEn, LrWe, MemEn;
	logic PcEn, PcWe, RegWe, CFlag;
	datapathPkg::immSelectT ImmSel;
	datapathPkg::lrSelectT LrSel;
	datapathPkg::op1SelectT Op1Sel;
	datapathPkg::op2SelectT Op2Sel;
	datapathPkg::pcSelectT PcSel;
	datapathPkg::rs1SelectT Rs1Sel;
	datapathPkg::rwSelectT RwSel;
	datapathPkg::aluOrSelectT AluOR;
	datapathPkg::wdSelectT WdSel;

	assign pwdata = SysBus; // ALUOUT drives the bus during a store

	control ctrl (
		.Clock (Clock), .rstN (rstN), .ir (Ir), .flags (Flags),
		.AddrSel (AddrSel), .AddrWe (AddrWe), .AluEn (AluEn), .AluWe (AluWe),
		.ImmSel (ImmSel), .IrWe (IrWe), .LrEn (LrEn), .LrSel (LrSel), .LrWe (LrWe),
		.MemEn (MemEn), .Op1Sel (Op1Sel), .Op2Sel (Op2Sel), .PcEn (PcEn),
		.PcSel (PcSel), .PcWe (PcWe), .RegWe (RegWe), .Rs1Sel (Rs1Sel),
		.RwSel (RwSel), .AluOR (AluOR), .WdSel (WdSel), .cFlag (CFlag),
		.psel (psel), .penable (penable), .pwrite (pwrite), .pready (pready),
		.halted (halted)
	);

	datapath dp (
		.Flags (Flags), .Ir (Ir), .Addr (paddr), .SysBus (SysBus),
		.AddrSel (AddrSel), .AddrWe (AddrWe), .AluEn (AluEn), .AluWe (AluWe),
		.CFlag (CFlag), .Clock (Clock), .DataIn (prdata), .ImmSel (ImmSel),
		.IrWe (IrWe), .LrEn (LrEn), .LrSel (LrSel), .LrWe (LrWe), .MemEn (MemEn),
		.rstN (rstN), .Op1Sel (Op1Sel), .Op2Sel (Op2Sel), .PcEn (PcEn),
		.PcSel (PcSel), .PcWe (PcWe), .RegWe (RegWe), .Rs1Sel (Rs1Sel),
		.RwSel (RwSel), .AluOR (AluOR), .WdSel (WdSel)
	);

endmodule

//--- verif/cpuTb.sv
// cpu testbench: APB memory with wait states, random programs and an instruction set model
`timescale 1ns/1ps

module cpuTb;

	localparam int w = datapathPkg::dataWidth;
	localparam int rounds = 8;
	localparam int pairsPerRound = 25; // 8 rounds give 200 ALU and STW pairs
	localparam int timeoutCycles = 2000;
	localparam logic [w-1:0] one = 1;

	logic Clock;
	logic rstN;
	logic [w-1:0] paddr;
	logic [w-1:0] pwdata;
	logic [w-1:0] prdata;
	logic psel, penable, pwrite, pready, halted;

	integer seed;
	logic [w-1:0] image [256];    // program of the current round over the fill pattern
	logic [w-1:0] apbMem [256];
	logic [w-1:0] modelMem [256];
	logic [w-1:0] modelRegs [8];
	logic [3:0] modelFlags;
	logic [w-1:0] expReadQ [$];   // fetch and load addresses in order
	logic [w-1:0] expWrAddrQ [$];
	logic [w-1:0] expWrDataQ [$];
	int progLen;
	int waitLeft;
	int xferCount;
	logic [w-1:0] heldAddr, heldData;
	logic heldWrite;

	cpu UUT (
		.Clock (Clock), .rstN (rstN), .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
		.psel (psel), .penable (penable), .pwrite (pwrite), .pready (pready),
		.halted (halted)
	);

	always #2 Clock = ~Clock;

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWrite(input logic [w-1:0] gotAddr, input logic [w-1:0] gotData,
			input logic [w-1:0] expAddr, input logic [w-1:0] expData);
		if (gotAddr !== expAddr) begin
			abortRun($sformatf("MISMATCH paddr on write: got %h, expected %h", gotAddr, expAddr));
		end else if (gotData !== expData) begin
			abortRun($sformatf("MISMATCH pwdata: got %h, expected %h", gotData, expData));
		end
	endtask

	task automatic checkRead(input logic [w-1:0] gotAddr, input logic [w-1:0] expAddr);
		if (gotAddr !== expAddr) begin
			abortRun($sformatf("MISMATCH paddr on read: got %h, expected %h", gotAddr, expAddr));
		end
	endtask

	// address, direction and store data must not move during wait states
	task automatic checkHeld(input string name, input logic [w-1:0] got, input logic [w-1:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("MISMATCH %s changed in transfer: got %h, expected %h",
				name, got, exp));
		end
	endtask

	task automatic checkFlagT(input logic [3:0] got, input logic [3:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("MISMATCH flags: got %h, expected %h", got, exp));
		end
	endtask

	task automatic checkReg(input int idx, input logic [w-1:0] got, input logic [w-1:0] exp);
		if (got !== exp) begin
			abortRun($sformatf("MISMATCH r%0d: got %h, expected %h", idx, got, exp));
		end
	endtask

	function automatic logic [w-1:0] encReg(opcodes::opcodeT op, logic [2:0] rd,
			logic [2:0] ra, logic [2:0] rb);
		return {op, rd, ra, rb, 2'b00};
	endfunction

	function automatic logic [w-1:0] encImm(opcodes::opcodeT op, logic [2:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [w-1:0] encMem(opcodes::opcodeT op, logic [2:0] rd,
			logic [2:0] ra, logic [4:0] imm);
		return {op, rd, ra, imm};
	endfunction

	function automatic logic [w-1:0] sext8(logic [7:0] v);
		return {{(w - 8){v[7]}}, v};
	endfunction

	function automatic logic [w-1:0] sext5(logic [4:0] v);
		return {{(w - 5){v[4]}}, v};
	endfunction

	function automatic void emit(input logic [w-1:0] word);
		image[progLen] = word;
		progLen++;
	endfunction

	// reference ALU from the instruction set rules, returns {N, Z, C, V, result}
	function automatic logic [w+3:0] aluModel(input opcodes::opcodeT op,
			input logic [w-1:0] a, input logic [w-1:0] b, input logic cin);
		logic [w:0] wide;
		logic [w-1:0] r;
		logic c, v;
		c = 1'b0;
		v = 1'b0;
		case (op)
			opcodes::opAnd: r = a & b;
			opcodes::opOr:  r = a | b;
			opcodes::opXor: r = a ^ b;
			opcodes::opSub: begin
				r = a - b;
				c = (a >= b); // carry set when no borrow
				v = (a[w-1] != b[w-1]) && (r[w-1] != a[w-1]);
			end
			default: begin // ADD, ADC and ADDI
				wide = {1'b0, a} + {1'b0, b} + {{w{1'b0}}, cin};
				r = wide[w-1:0];
				c = wide[w];
				v = (a[w-1] == b[w-1]) && (r[w-1] != a[w-1]);
			end
		endcase
		return {r[w-1], r == '0, c, v, r};
	endfunction

	task automatic buildProgram();
		logic [2:0] rd, rs, rt;
		logic [4:0] off;
		int kind;
		int blAt;
		progLen = 0;
		for (int i = 0; i < 256; i++) begin
			image[i] = {~i[7:0], i[7:0]};
		end
		emit(encImm(opcodes::opAddi, 3'd6, 8'hE0)); // r6 = 0xFFE0, data base
		for (int k = 0; k < pairsPerRound; k++) begin
			if (($random(seed) & 7) == 0) begin
				emit(encImm(opcodes::opBeq, 3'd0, 8'($random(seed) & 3))); // short forward skip
			end
			rd = 3'($unsigned($random(seed)) % 6);
			rs = 3'($random(seed));
			rt = 3'($random(seed));
			kind = $unsigned($random(seed)) % 7;
			case (kind)
				0: emit(encReg(opcodes::opAdd, rd, rs, rt));
				1: emit(encReg(opcodes::opAdc, rd, rs, rt));
				2: emit(encReg(opcodes::opSub, rd, rs, rt));
				3: emit(encReg(opcodes::opAnd, rd, rs, rt));
				4: emit(encReg(opcodes::opOr, rd, rs, rt));
				5: emit(encReg(opcodes::opXor, rd, rs, rt));
				default: emit(encImm(opcodes::opAddi, rd, 8'($random(seed))));
			endcase
			emit(encMem(opcodes::opStw, rd, 3'd6, 5'($random(seed))));
		end
		// store, load back, store the loaded register elsewhere
		for (int k = 0; k < 3; k++) begin
			off = 5'($random(seed));
			rs = 3'($unsigned($random(seed)) % 6);
			rd = 3'($unsigned($random(seed)) % 6);
			emit(encMem(opcodes::opStw, rs, 3'd6, off));
			emit(encMem(opcodes::opLdw, rd, 3'd6, off));
			emit(encMem(opcodes::opStw, rd, 3'd6, 5'(off + 5'd1)));
		end
		emit(encReg(opcodes::opXor, 3'd5, 3'd5, 3'd5)); // zero result sets Z
		emit(encImm(opcodes::opBeq, 3'd0, 8'd1));       // taken
		emit(encImm(opcodes::opAddi, 3'd5, 8'h11));
		emit(encMem(opcodes::opStw, 3'd5, 3'd6, 5'd0));
		emit(encImm(opcodes::opAddi, 3'd5, 8'd1));      // clears Z
		emit(encImm(opcodes::opBeq, 3'd0, 8'd1));       // not taken
		emit(encImm(opcodes::opAddi, 3'd5, 8'h22));
		emit(encMem(opcodes::opStw, 3'd5, 3'd6, 5'd1));
		blAt = progLen;
		emit('0);
		emit(encMem(opcodes::opStw, 3'd7, 3'd6, 5'd2)); // return address seen in r7
		emit({opcodes::opHalt, 11'd0});
		image[blAt] = encImm(opcodes::opBl, 3'd0, 8'(progLen - blAt - 1));
		// subroutine past the HALT
		emit(encImm(opcodes::opAddi, 3'd4, 8'($random(seed))));
		emit(encMem(opcodes::opStw, 3'd4, 3'd6, 5'd3));
		emit({opcodes::opRet, 11'd0});
	endtask

	task automatic runModel();
		logic [w-1:0] pc, lr, word, addr;
		logic [w+3:0] res;
		opcodes::opcodeT op;
		logic [2:0] rd, ra, rb;
		logic cin;
		int steps;
		pc = '0;
		lr = '0;
		modelFlags = '0;
		for (int i = 0; i < 8; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			modelMem[i] = image[i];
		end
		for (steps = 0; steps < 1000; steps++) begin
			expReadQ.push_back(pc);
			word = modelMem[pc[7:0]];
			op = opcodes::opcodeT'(word[15:11]);
			rd = word[10:8];
			ra = word[7:5];
			rb = word[4:2];
			pc = pc + one;
			if (op == opcodes::opHalt) break;
			case (op)
				opcodes::opAddi: begin
					res = aluModel(op, modelRegs[rd], sext8(word[7:0]), 1'b0);
					modelRegs[rd] = res[w-1:0];
					modelFlags = res[w+3:w];
				end
				opcodes::opLdw: begin
					addr = modelRegs[ra] + sext5(word[4:0]);
					expReadQ.push_back(addr);
					modelRegs[rd] = modelMem[addr[7:0]];
				end
				opcodes::opStw: begin
					addr = modelRegs[ra] + sext5(word[4:0]);
					expWrAddrQ.push_back(addr);
					expWrDataQ.push_back(modelRegs[rd]);
					modelMem[addr[7:0]] = modelRegs[rd];
				end
				opcodes::opBeq: begin
					if (modelFlags[opcodes::flagZ]) pc = pc + sext8(word[7:0]);
				end
				opcodes::opBl: begin
					lr = pc;
					modelRegs[opcodes::linkReg] = pc;
					pc = pc + sext8(word[7:0]);
				end
				opcodes::opRet: pc = lr;
				default: begin // register to register
					cin = modelFlags[opcodes::flagC] && (op == opcodes::opAdc);
					res = aluModel(op, modelRegs[ra], modelRegs[rb], cin);
					modelRegs[rd] = res[w-1:0];
					modelFlags = res[w+3:w];
				end
			endcase
		end
		if (steps >= 1000) abortRun("model did not reach HALT");
	endtask

	// APB slave, random wait states with an occasional long stall
	always @(posedge Clock) begin
		if (!rstN) begin
			pready <= 1'b0;
		end else if (psel && !penable) begin
			waitLeft = $unsigned($random(seed)) % 4;
			if (($random(seed) & 7) == 0) waitLeft = waitLeft + 8 + $unsigned($random(seed)) % 8;
			heldAddr = paddr;
			heldWrite = pwrite;
			heldData = pwdata;
			prdata <= apbMem[paddr[7:0]];
			pready <= (waitLeft == 0);
		end else if (psel && penable) begin
			checkHeld("paddr", paddr, heldAddr);
			checkHeld("pwrite", w'(pwrite), w'(heldWrite));
			if (heldWrite) checkHeld("pwdata", pwdata, heldData);
			if (pready) begin
				xferCount++;
				pready <= 1'b0;
				if (pwrite) begin
					if (expWrAddrQ.size() == 0) begin
						abortRun("APB write while the model expects none");
					end else begin
						checkWrite(paddr, pwdata, expWrAddrQ.pop_front(), expWrDataQ.pop_front());
						apbMem[paddr[7:0]] = pwdata;
					end
				end else if (expReadQ.size() == 0) begin
					abortRun("APB read while the model expects none");
				end else begin
					checkRead(paddr, expReadQ.pop_front());
				end
			end else begin
				waitLeft--;
				pready <= (waitLeft == 0);
			end
		end
	end

	task automatic resetDut();
		@(posedge Clock);
		rstN <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(posedge Clock);
			// first edge still shows the previous round
			if (i > 0 && (psel || penable || pwrite || halted)) begin
				abortRun("APB outputs or halted not low during reset");
			end
		end
		rstN <= 1'b1;
		@(posedge Clock);
		if (psel || penable || pwrite || halted) abortRun("APB outputs not low after reset");
	endtask

	task automatic waitForHalt();
		int idle;
		int lastCount;
		idle = 0;
		lastCount = xferCount;
		while (!halted) begin
			@(posedge Clock);
			if (xferCount != lastCount) begin
				lastCount = xferCount;
				idle = 0;
			end else begin
				idle++;
			end
			if (idle >= timeoutCycles) abortRun("timeout waiting for an APB transfer or halted");
		end
	endtask

	task automatic watchIdle();
		for (int i = 0; i < timeoutCycles; i++) begin
			@(posedge Clock);
			if (psel) abortRun("APB transfer started after HALT");
			if (!halted) abortRun("halted dropped before reset");
		end
	endtask

	initial begin
		seed = 77;
		Clock = 1'b0;
		rstN = 1'b0;
		pready = 1'b0;
		prdata = '0;
		xferCount = 0;
		for (int r = 0; r < rounds; r++) begin
			buildProgram();
			runModel();
			for (int i = 0; i < 256; i++) begin
				apbMem[i] = image[i];
			end
			resetDut();
			waitForHalt();
			watchIdle();
			if (expReadQ.size() != 0 || expWrAddrQ.size() != 0) begin
				abortRun("DUT halted with expected transfers still outstanding");
			end
			checkFlagT(UUT.ctrl.flagReg, modelFlags);
			for (int i = 0; i < 8; i++) begin
				checkReg(i, UUT.dp.regs.regs[i], modelRegs[i]);
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- vlog.f
common/opcodes.sv
common/datapathPkg.sv
datapath/trisreg.sv
datapath/regBlock.sv
datapath/aluDecode.sv
datapath/alu.sv
datapath/datapath.sv
design/control.sv
design/cpu.sv
verif/cpuTb.sv

//--- Makefile
# Verilator build and run of the cpu testbench

VERILATOR ?= verilator
TOP ?= cpuTb
SEED_ARGS ?= +verilator+seed+77
OBJ_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -f vlog.f --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
